//--- i2c_config.svh
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// Command FIFO depth as log2 (8 entries)
`define I2C_CMD_FIFO_DEPTH_LOG2 3

// Write and read data FIFO depth as log2
`define I2C_DATA_FIFO_DEPTH_LOG2 3

// Quarter SCL period in clk cycles after reset
`define I2C_DEFAULT_PRESCALE 16'd125

// Register offsets on the 16-bit Wishbone bus
`define I2C_REG_STATUS 3'h0
`define I2C_REG_CMD 3'h2
`define I2C_REG_DATA 3'h4
`define I2C_REG_PRESCALE 3'h6

`endif

//--- i2c_pkg.sv
package i2c_pkg;

    // Queued command with flags above the address
    typedef struct packed {
        logic       stop;
        logic       rsvd;       // Old write-multiple slot
        logic       write;
        logic       read;
        logic       start;
        logic [6:0] address;
    } i2c_cmd_t;

    // Data register payload
    typedef struct packed {
        logic       last;
        logic [7:0] value;
    } i2c_data_t;

    // Command register image
    typedef struct packed {
        logic [2:0] rsvd_hi;
        logic       stop;
        logic       rsvd11;
        logic       write;
        logic       read;
        logic       start;
        logic       rsvd7;
        logic [6:0] address;
    } wb_cmd_view_t;

    // Data register image
    typedef struct packed {
        logic [6:0] rsvd_hi;
        i2c_data_t  payload;
    } wb_data_view_t;

    // One bus write word, decoded per target register
    typedef union packed {
        wb_cmd_view_t  cmd;
        wb_data_view_t dat;
    } wb_word_u;

    // Engine status, missed_ack is a one-cycle pulse
    typedef struct packed {
        logic missed_ack;
        logic bus_control;
        logic busy;
    } i2c_status_t;

    typedef logic [15:0] prescale_t;

endpackage

//--- i2c_fifo.sv
`timescale 1ns/1ps

module i2c_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH_LOG2 = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  pop_i,
    output logic [DATA_WIDTH-1:0] data_o,
    output logic                  empty_o,
    output logic                  full_o
);
    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    // Extra MSB tells full from empty
    logic [DEPTH_LOG2:0]   wr_ptr_q;
    logic [DEPTH_LOG2:0]   rd_ptr_q;
    logic                  do_push;
    logic                  do_pop;

    assign empty_o = wr_ptr_q == rd_ptr_q;
    assign full_o  = (wr_ptr_q[DEPTH_LOG2] != rd_ptr_q[DEPTH_LOG2]) &&
                     (wr_ptr_q[DEPTH_LOG2-1:0] == rd_ptr_q[DEPTH_LOG2-1:0]);

    // Push on full and pop on empty are dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // First-word view
    assign data_o = mem[rd_ptr_q[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q[DEPTH_LOG2-1:0]] <= data_i;
        end
    end

    a_not_empty_and_full: assert property (@(posedge clk) disable iff (rst)
        !(empty_o && full_o));

endmodule

//--- i2c_wb_regs.sv
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_wb_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2:0]           wbs_adr_i,
    input  i2c_pkg::wb_word_u    wbs_dat_i,
    output logic [15:0]          wbs_dat_o,
    input  logic                 wbs_we_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_cyc_i,
    output logic                 wbs_ack_o,
    input  logic                 cmd_full_i,
    input  logic                 cmd_empty_i,
    input  logic                 wr_full_i,
    input  logic                 wr_empty_i,
    input  logic                 rd_full_i,
    input  logic                 rd_empty_i,
    input  i2c_pkg::i2c_data_t   rd_data_i,
    input  i2c_pkg::i2c_status_t status_i,
    output logic                 cmd_push_o,
    output i2c_pkg::i2c_cmd_t    cmd_o,
    output logic                 wr_push_o,
    output logic [7:0]           wr_data_o,
    output logic                 rd_pop_o,
    output i2c_pkg::prescale_t   prescale_o
);
    import i2c_pkg::*;

    logic        ack_q;
    logic        wr_req;
    logic        rd_req;
    logic        any_flag;
    logic        status_rd;
    logic [15:0] dat_q;
    i2c_cmd_t    shadow_q;
    prescale_t   prescale_q;
    logic        miss_ack_q;
    logic        cmd_ovf_q;
    logic        wr_ovf_q;
    wb_word_u    rd_word;

    // One side effect per access, the ack cycle is masked
    assign wr_req = wbs_cyc_i && wbs_stb_i && !ack_q && wbs_we_i;
    assign rd_req = wbs_cyc_i && wbs_stb_i && !ack_q && !wbs_we_i;

    assign wbs_ack_o  = ack_q;
    assign wbs_dat_o  = dat_q;
    assign prescale_o = prescale_q;

    // Command view of the write word
    always_comb begin
        cmd_o.address = wbs_dat_i.cmd.address;
        cmd_o.start   = wbs_dat_i.cmd.start;
        cmd_o.read    = wbs_dat_i.cmd.read;
        cmd_o.write   = wbs_dat_i.cmd.write;
        cmd_o.stop    = wbs_dat_i.cmd.stop;
        cmd_o.rsvd    = 1'b0;
    end

    assign any_flag = cmd_o.start || cmd_o.read || cmd_o.write || cmd_o.stop;

    // FIFO strobes
    assign cmd_push_o = wr_req && wbs_adr_i == `I2C_REG_CMD && any_flag;
    assign wr_push_o  = wr_req && wbs_adr_i == `I2C_REG_DATA;
    assign wr_data_o  = wbs_dat_i.dat.payload.value;
    assign rd_pop_o   = rd_req && wbs_adr_i == `I2C_REG_DATA;
    assign status_rd  = rd_req && wbs_adr_i == `I2C_REG_STATUS;

    // Read mux
    always_comb begin
        rd_word = '0;
        case (wbs_adr_i)
            `I2C_REG_STATUS: begin
                // Bit 2 is bus activity, not tracked here
                rd_word = {rd_full_i, rd_empty_i, wr_ovf_q, wr_full_i,
                           wr_empty_i, cmd_ovf_q, cmd_full_i, cmd_empty_i,
                           4'd0, miss_ack_q, 1'b0,
                           status_i.bus_control, status_i.busy};
            end
            `I2C_REG_CMD: begin
                rd_word.cmd.address = shadow_q.address;
                rd_word.cmd.start   = shadow_q.start;
                rd_word.cmd.read    = shadow_q.read;
                rd_word.cmd.write   = shadow_q.write;
                rd_word.cmd.stop    = shadow_q.stop;
            end
            `I2C_REG_DATA: begin
                // Head of the read FIFO, popped by this access
                rd_word.dat.payload = rd_data_i;
            end
            `I2C_REG_PRESCALE: begin
                rd_word = prescale_q;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    // Ack, prescale and sticky flags
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q      <= 1'b0;
            prescale_q <= `I2C_DEFAULT_PRESCALE;
            miss_ack_q <= 1'b0;
            cmd_ovf_q  <= 1'b0;
            wr_ovf_q   <= 1'b0;
        end else begin
            ack_q <= wbs_cyc_i && wbs_stb_i && !ack_q;
            if (wr_req && wbs_adr_i == `I2C_REG_PRESCALE) begin
                prescale_q <= wbs_dat_i;
            end
            if (status_rd) begin
                // A fresh miss pulse survives the clear
                miss_ack_q <= status_i.missed_ack;
                cmd_ovf_q  <= 1'b0;
                wr_ovf_q   <= 1'b0;
            end else begin
                miss_ack_q <= miss_ack_q || status_i.missed_ack;
                cmd_ovf_q  <= cmd_ovf_q || (cmd_push_o && cmd_full_i);
                wr_ovf_q   <= wr_ovf_q || (wr_push_o && wr_full_i);
            end
        end
    end

    // Read data and command shadow
    always_ff @(posedge clk) begin
        if (rd_req) begin
            dat_q <= rd_word;
        end
        if (wr_req && wbs_adr_i == `I2C_REG_CMD) begin
            shadow_q <= cmd_o;
        end
    end

    // Single-cycle ack per access
    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wbs_ack_o |=> !wbs_ack_o);

endmodule

//--- i2c_byte_engine.sv
`timescale 1ns/1ps

module i2c_byte_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  i2c_pkg::prescale_t   prescale_i,
    input  i2c_pkg::i2c_cmd_t    cmd_i,
    input  logic                 cmd_empty_i,
    input  logic [7:0]           wr_data_i,
    input  logic                 wr_empty_i,
    input  logic                 rd_full_i,
    input  logic                 scl_i,
    input  logic                 sda_i,
    output logic                 cmd_pop_o,
    output logic                 wr_pop_o,
    output logic                 rd_push_o,
    output i2c_pkg::i2c_data_t   rd_data_o,
    output logic                 scl_o,
    output logic                 scl_t,
    output logic                 sda_o,
    output logic                 sda_t,
    output i2c_pkg::i2c_status_t status_o
);
    import i2c_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_ADDR,
        ST_ADDR_ACK,
        ST_DATA,
        ST_DATA_ACK,
        ST_STOP
    } state_t;

    state_t     state_q;
    prescale_t  cnt_q;
    logic [1:0] phase_q;
    logic [2:0] bit_q;
    logic [7:0] shift_q;
    i2c_cmd_t   cmd_q;
    logic       bus_ctl_q;
    logic       miss_q;
    logic       scl_q;
    logic       sda_q;
    logic       stall;
    logic       tick;
    logic       phase_end;
    logic       sample;
    logic       byte_end;
    logic [7:0] addr_byte;
    logic       scl_lvl;
    logic       sda_lvl;

    // Address byte carries R/W in bit 0
    assign addr_byte = {cmd_q.address, cmd_q.read};

    // Back-pressure before the data byte
    assign stall = state_q == ST_DATA && bit_q == 3'd7 && phase_q == 2'd0 &&
                   (cmd_q.write ? wr_empty_i : rd_full_i);

    // Phase tick every prescale cycles
    assign tick      = state_q != ST_IDLE && !stall && cnt_q <= 16'd1;
    assign phase_end = tick && phase_q == 2'd3;
    assign sample    = tick && phase_q == 2'd1;
    assign byte_end  = phase_end && state_q == ST_DATA && bit_q == 3'd0;

    assign cmd_pop_o = state_q == ST_IDLE && !cmd_empty_i;
    assign wr_pop_o  = byte_end && cmd_q.write;
    assign rd_push_o = byte_end && cmd_q.read;

    assign rd_data_o.last  = cmd_q.stop;
    assign rd_data_o.value = shift_q;

    assign status_o.busy        = state_q != ST_IDLE || !cmd_empty_i;
    assign status_o.bus_control = bus_ctl_q;
    assign status_o.missed_ack  = miss_q;

    // Open drain, only the enables toggle
    assign scl_o = 1'b0;
    assign sda_o = 1'b0;
    assign scl_t = scl_q;
    assign sda_t = sda_q;

    // Line levels per state and phase, SCL high in phases 1 and 2
    always_comb begin
        scl_lvl = phase_q == 2'd1 || phase_q == 2'd2;
        sda_lvl = 1'b1;
        case (state_q)
            ST_IDLE: begin
                // Holding the bus keeps SCL low
                scl_lvl = !bus_ctl_q;
            end
            ST_START: begin
                sda_lvl = phase_q < 2'd2;
            end
            ST_ADDR: begin
                sda_lvl = addr_byte[bit_q];
            end
            ST_DATA: begin
                sda_lvl = cmd_q.read || wr_data_i[bit_q];
            end
            ST_DATA_ACK: begin
                // Master ACK on reads, NACK before stop
                sda_lvl = cmd_q.write || cmd_q.stop;
            end
            ST_STOP: begin
                scl_lvl = phase_q != 2'd0;
                sda_lvl = phase_q >= 2'd2;
            end
            default: begin
                sda_lvl = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            phase_q   <= 2'd0;
            bit_q     <= 3'd7;
            bus_ctl_q <= 1'b0;
            miss_q    <= 1'b0;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
        end else begin
            scl_q  <= scl_lvl;
            sda_q  <= sda_lvl;
            // Slave ACK sampled mid-high
            miss_q <= sample && sda_i &&
                      (state_q == ST_ADDR_ACK || (state_q == ST_DATA_ACK && cmd_q.write));
            if (state_q == ST_IDLE || stall || tick) begin
                cnt_q <= prescale_i;
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
            if (tick) begin
                phase_q <= phase_q + 1'b1;
            end
            // Wraps 0 to 7 at the end of each byte
            if (phase_end && (state_q == ST_ADDR || state_q == ST_DATA)) begin
                bit_q <= bit_q - 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    // Read plus write is dropped silently
                    if (cmd_pop_o && (cmd_i.read != cmd_i.write)) begin
                        if (cmd_i.start || !bus_ctl_q) begin
                            state_q   <= ST_START;
                            bus_ctl_q <= 1'b1;
                        end else begin
                            state_q <= ST_DATA;
                        end
                    end else if (cmd_pop_o && !cmd_i.read && cmd_i.stop && bus_ctl_q) begin
                        state_q <= ST_STOP;
                    end
                end
                ST_START: begin
                    if (phase_end) begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (phase_end && bit_q == 3'd0) begin
                        state_q <= ST_ADDR_ACK;
                    end
                end
                ST_ADDR_ACK: begin
                    if (phase_end) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (byte_end) begin
                        state_q <= ST_DATA_ACK;
                    end
                end
                ST_DATA_ACK: begin
                    if (phase_end) begin
                        state_q <= cmd_q.stop ? ST_STOP : ST_IDLE;
                    end
                end
                ST_STOP: begin
                    if (phase_end) begin
                        state_q   <= ST_IDLE;
                        bus_ctl_q <= 1'b0;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Command latch and receive shifter, MSB first
    always_ff @(posedge clk) begin
        if (cmd_pop_o) begin
            cmd_q <= cmd_i;
        end
        if (sample && state_q == ST_DATA) begin
            shift_q <= {shift_q[6:0], sda_i};
        end
    end

    a_open_drain: assert property (@(posedge clk) !scl_o && !sda_o);

    // No other device stretches SCL once released
    a_no_stretch: assert property (@(posedge clk) disable iff (rst) scl_t |-> scl_i);

endmodule

//--- i2c_master_wbs_top.sv
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_master_wbs_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  wbs_adr_i,
    input  logic [15:0] wbs_dat_i,
    output logic [15:0] wbs_dat_o,
    input  logic        wbs_we_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_cyc_i,
    output logic        wbs_ack_o,
    input  logic        i2c_scl_i,
    output logic        i2c_scl_o,
    output logic        i2c_scl_t,
    input  logic        i2c_sda_i,
    output logic        i2c_sda_o,
    output logic        i2c_sda_t
);
    import i2c_pkg::*;

    i2c_cmd_t    cmd_in;
    i2c_cmd_t    cmd_head;
    logic        cmd_push;
    logic        cmd_pop;
    logic        cmd_empty;
    logic        cmd_full;
    logic [7:0]  wr_in;
    logic [7:0]  wr_head;
    logic        wr_push;
    logic        wr_pop;
    logic        wr_empty;
    logic        wr_full;
    i2c_data_t   rd_in;
    i2c_data_t   rd_head;
    logic        rd_push;
    logic        rd_pop;
    logic        rd_empty;
    logic        rd_full;
    i2c_status_t status;
    prescale_t   prescale;

    i2c_wb_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .wbs_dat_o   (wbs_dat_o),
        .wbs_we_i    (wbs_we_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_ack_o   (wbs_ack_o),
        .cmd_full_i  (cmd_full),
        .cmd_empty_i (cmd_empty),
        .wr_full_i   (wr_full),
        .wr_empty_i  (wr_empty),
        .rd_full_i   (rd_full),
        .rd_empty_i  (rd_empty),
        .rd_data_i   (rd_head),
        .status_i    (status),
        .cmd_push_o  (cmd_push),
        .cmd_o       (cmd_in),
        .wr_push_o   (wr_push),
        .wr_data_o   (wr_in),
        .rd_pop_o    (rd_pop),
        .prescale_o  (prescale)
    );

    i2c_fifo #(
        .DATA_WIDTH ($bits(i2c_cmd_t)),
        .DEPTH_LOG2 (`I2C_CMD_FIFO_DEPTH_LOG2)
    ) u_cmd_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (cmd_push),
        .data_i  (cmd_in),
        .pop_i   (cmd_pop),
        .data_o  (cmd_head),
        .empty_o (cmd_empty),
        .full_o  (cmd_full)
    );

    i2c_fifo #(
        .DATA_WIDTH (8),
        .DEPTH_LOG2 (`I2C_DATA_FIFO_DEPTH_LOG2)
    ) u_wr_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (wr_push),
        .data_i  (wr_in),
        .pop_i   (wr_pop),
        .data_o  (wr_head),
        .empty_o (wr_empty),
        .full_o  (wr_full)
    );

    // Read bytes carry the stop flag as last
    i2c_fifo #(
        .DATA_WIDTH ($bits(i2c_data_t)),
        .DEPTH_LOG2 (`I2C_DATA_FIFO_DEPTH_LOG2)
    ) u_rd_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (rd_push),
        .data_i  (rd_in),
        .pop_i   (rd_pop),
        .data_o  (rd_head),
        .empty_o (rd_empty),
        .full_o  (rd_full)
    );

    i2c_byte_engine u_engine (
        .clk         (clk),
        .rst         (rst),
        .prescale_i  (prescale),
        .cmd_i       (cmd_head),
        .cmd_empty_i (cmd_empty),
        .wr_data_i   (wr_head),
        .wr_empty_i  (wr_empty),
        .rd_full_i   (rd_full),
        .scl_i       (i2c_scl_i),
        .sda_i       (i2c_sda_i),
        .cmd_pop_o   (cmd_pop),
        .wr_pop_o    (wr_pop),
        .rd_push_o   (rd_push),
        .rd_data_o   (rd_in),
        .scl_o       (i2c_scl_o),
        .scl_t       (i2c_scl_t),
        .sda_o       (i2c_sda_o),
        .sda_t       (i2c_sda_t),
        .status_o    (status)
    );

endmodule

//--- tb_i2c_slave_model.sv
`timescale 1ns/1ps

module tb_i2c_slave_model #(
    parameter logic [6:0] SLAVE_ADDR = 7'h50,
    parameter logic [7:0] READ_BASE  = 8'hA5
) (
    input  logic       scl_i,
    input  logic       sda_i,
    output logic       sda_o,
    output logic [7:0] last_rx_o
);
    typedef enum logic [2:0] {
        SL_IDLE,
        SL_ADDR,
        SL_ADDR_ACK,
        SL_WRITE,
        SL_WR_ACK,
        SL_READ,
        SL_RD_ACK
    } sl_state_t;

    sl_state_t  state;
    logic       scl_prev;
    logic       sda_prev;
    logic       rw;
    logic       nack;
    logic [3:0] cnt;
    logic [7:0] shift;
    logic [7:0] tx_byte;
    logic [7:0] rd_next;

    initial begin
        state     = SL_IDLE;
        scl_prev  = 1'b1;
        sda_prev  = 1'b1;
        sda_o     = 1'b1;
        last_rx_o = 8'h00;
        rw        = 1'b0;
        nack      = 1'b0;
        cnt       = 4'd0;
        shift     = 8'h00;
        tx_byte   = READ_BASE;
        rd_next   = READ_BASE;
    end

    // Edge detection on both lines in one process
    always @(scl_i or sda_i) begin
        if (scl_i === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda_i === 1'b0) begin
            // Start or repeated start
            state = SL_ADDR;
            cnt   = 4'd0;
            sda_o = 1'b1;
        end else if (scl_i === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b0 &&
                     sda_i === 1'b1) begin
            // Stop
            state = SL_IDLE;
            sda_o = 1'b1;
        end else if (scl_i === 1'b1 && scl_prev === 1'b0) begin
            // Rising SCL, sample
            case (state)
                SL_ADDR, SL_WRITE: begin
                    shift = {shift[6:0], sda_i};
                    cnt   = cnt + 4'd1;
                end
                SL_RD_ACK: begin
                    nack = sda_i;
                end
                default: begin
                end
            endcase
        end else if (scl_i === 1'b0 && scl_prev === 1'b1) begin
            // Falling SCL, drive the next bit
            case (state)
                SL_ADDR: begin
                    if (cnt == 4'd8) begin
                        if (shift[7:1] == SLAVE_ADDR) begin
                            rw    = shift[0];
                            sda_o = 1'b0;
                            state = SL_ADDR_ACK;
                        end else begin
                            // Not us, wait for the next start
                            state = SL_IDLE;
                        end
                    end
                end
                SL_ADDR_ACK: begin
                    if (rw) begin
                        tx_byte = rd_next;
                        sda_o   = tx_byte[7];
                        cnt     = 4'd1;
                        state   = SL_READ;
                    end else begin
                        sda_o = 1'b1;
                        cnt   = 4'd0;
                        state = SL_WRITE;
                    end
                end
                SL_WRITE: begin
                    if (cnt == 4'd8) begin
                        last_rx_o = shift;
                        sda_o     = 1'b0;
                        state     = SL_WR_ACK;
                    end
                end
                SL_WR_ACK: begin
                    sda_o = 1'b1;
                    cnt   = 4'd0;
                    state = SL_WRITE;
                end
                SL_READ: begin
                    if (cnt == 4'd8) begin
                        // Release for the master ACK
                        sda_o = 1'b1;
                        state = SL_RD_ACK;
                    end else begin
                        sda_o = tx_byte[7 - cnt];
                        cnt   = cnt + 4'd1;
                    end
                end
                SL_RD_ACK: begin
                    rd_next = rd_next + 8'd1;
                    if (nack) begin
                        state = SL_IDLE;
                    end else begin
                        tx_byte = rd_next;
                        sda_o   = tx_byte[7];
                        cnt     = 4'd1;
                        state   = SL_READ;
                    end
                end
                default: begin
                end
            endcase
        end
        scl_prev = scl_i;
        sda_prev = sda_i;
    end

endmodule

//--- tb_i2c_master_wbs.sv
`timescale 1ns/1ps

module tb_i2c_master_wbs;

    localparam int NAME_BITS = 8 * 24;

    logic        clk;
    logic        rst;
    logic [2:0]  wbs_adr;
    logic [15:0] wbs_dat_w;
    logic [15:0] wbs_dat_r;
    logic        wbs_we;
    logic        wbs_stb;
    logic        wbs_cyc;
    logic        wbs_ack;
    logic        dut_scl_o;
    logic        dut_scl_t;
    logic        dut_sda_o;
    logic        dut_sda_t;
    logic        scl_bus;
    logic        sda_bus;
    logic        slave_sda;
    logic [7:0]  slave_last_rx;

    // Parsed operations from the data file
    logic [7:0]           op_q[$];
    logic [2:0]           addr_q[$];
    logic [15:0]          data_q[$];
    logic [15:0]          mask_q[$];
    logic [NAME_BITS-1:0] name_q[$];

    int   op_count;
    int   err_count;
    logic ops_loaded;

    // Wired-AND open-drain lines, pulled up when released
    assign scl_bus = dut_scl_t ? 1'b1 : dut_scl_o;
    assign sda_bus = (dut_sda_t ? 1'b1 : dut_sda_o) & slave_sda;

    i2c_master_wbs_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .wbs_adr_i (wbs_adr),
        .wbs_dat_i (wbs_dat_w),
        .wbs_dat_o (wbs_dat_r),
        .wbs_we_i  (wbs_we),
        .wbs_stb_i (wbs_stb),
        .wbs_cyc_i (wbs_cyc),
        .wbs_ack_o (wbs_ack),
        .i2c_scl_i (scl_bus),
        .i2c_scl_o (dut_scl_o),
        .i2c_scl_t (dut_scl_t),
        .i2c_sda_i (sda_bus),
        .i2c_sda_o (dut_sda_o),
        .i2c_sda_t (dut_sda_t)
    );

    tb_i2c_slave_model #(
        .SLAVE_ADDR (7'h50),
        .READ_BASE  (8'hA5)
    ) u_slave (
        .scl_i     (scl_bus),
        .sda_i     (sda_bus),
        .sda_o     (slave_sda),
        .last_rx_o (slave_last_rx)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input logic [NAME_BITS-1:0] name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (expected !== actual) begin
            err_count = err_count + 1;
            $display("[ERROR] %0s: expected %04h, actual %04h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // One Wishbone access, inputs change 2 ns after the edge
    task automatic wb_access(input logic [2:0] addr, input logic [15:0] wdata, input logic we,
                             output logic [15:0] rdata);
        @(posedge clk);
        #2;
        wbs_adr   = addr;
        wbs_dat_w = wdata;
        wbs_we    = we;
        wbs_cyc   = 1'b1;
        wbs_stb   = 1'b1;
        // Ack is registered, look just after the edge
        do begin
            @(posedge clk);
            #1;
        end while (wbs_ack !== 1'b1);
        rdata = wbs_dat_r;
        #1;
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
    endtask

    // Status polls until busy drops, ORing every word seen
    task automatic wait_idle(output logic [15:0] seen);
        logic [15:0] st;
        seen = 16'h0000;
        do begin
            wb_access(3'h0, 16'h0000, 1'b0, st);
            seen = seen | st;
        end while (st[0] !== 1'b0);
    endtask

    task automatic load_ops();
        int                   fd;
        int                   n;
        logic [7:0]           op;
        logic [15:0]          addr_v;
        logic [15:0]          data_v;
        logic [15:0]          mask_v;
        logic [NAME_BITS-1:0] name_v;
        logic [8*128-1:0]     rest;
        fd = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb_input.txt for reading");
            $display("SOME TESTS FAILED");
            $fatal(1, "Missing stimulus file");
        end else begin
            while ($fscanf(fd, " %c", op) == 1) begin
                if (op == "#") begin
                    // Comment line
                    n = $fgets(rest, fd);
                end else begin
                    n = $fscanf(fd, "%h %h %h %s", addr_v, data_v, mask_v, name_v);
                    if (n != 4) begin
                        $display("Malformed line in tb_input.txt after %0d operations",
                                 op_q.size());
                        $display("SOME TESTS FAILED");
                        $fatal(1, "Bad stimulus file");
                    end else begin
                        op_q.push_back(op);
                        addr_q.push_back(addr_v[2:0]);
                        data_q.push_back(data_v);
                        mask_q.push_back(mask_v);
                        name_q.push_back(name_v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Watchdog sized from the number of operations
    initial begin
        wait (ops_loaded === 1'b1);
        repeat (op_count * 4000) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", op_count * 4000);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main_seq
        int          idx;
        logic [15:0] rd;
        rst        = 1'b1;
        wbs_adr    = 3'h0;
        wbs_dat_w  = 16'h0000;
        wbs_we     = 1'b0;
        wbs_stb    = 1'b0;
        wbs_cyc    = 1'b0;
        err_count  = 0;
        op_count   = 0;
        ops_loaded = 1'b0;
        load_ops();
        op_count   = op_q.size();
        ops_loaded = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        for (idx = 0; idx < op_count; idx++) begin
            case (op_q[idx])
                "W": begin
                    wb_access(addr_q[idx], data_q[idx], 1'b1, rd);
                end
                "R": begin
                    wb_access(addr_q[idx], 16'h0000, 1'b0, rd);
                    check(name_q[idx], data_q[idx] & mask_q[idx], rd & mask_q[idx]);
                end
                "I": begin
                    wait_idle(rd);
                    check(name_q[idx], data_q[idx] & mask_q[idx], rd & mask_q[idx]);
                end
                "S": begin
                    // Byte the slave took from the bus
                    check(name_q[idx], data_q[idx] & mask_q[idx],
                          {8'h00, slave_last_rx} & mask_q[idx]);
                end
                default: begin
                    $display("Unknown operation '%c' in tb_input.txt", op_q[idx]);
                    $display("SOME TESTS FAILED");
                    $fatal(1, "Bad stimulus file");
                end
            endcase
        end
        if (op_count > 0 && err_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "No operations run or a check failed");
        end
    end

endmodule

//--- tb_input.txt
# op addr data mask name (hex fields)
# W write data | R read, expect data under mask | I poll until idle, OR of polls vs data | S slave byte
R 0 4900 ffff rst_status
R 6 007d ffff rst_prescale
W 6 0002 0000 set_prescale
R 6 0002 ffff prescale_readback
W 2 0050 0000 cmd_no_flags
R 2 0050 ffff cmd_shadow
R 0 4900 ffff nothing_queued
W 4 003c 0000 push_wr_byte
W 2 1450 0000 cmd_write_stop
I 0 0000 0008 write_no_miss
S 0 003c 00ff slave_rx_byte
R 0 4900 ffff write_done_status
W 2 1250 0000 cmd_read_stop
I 0 0000 0008 read_no_miss
R 4 01a5 01ff read_byte_last
R 0 4900 ffff rd_fifo_empty
W 4 0011 0000 push_nack_byte
W 2 1422 0000 cmd_nack_addr
I 0 0008 0008 miss_ack_set
R 0 4900 ffff miss_ack_cleared
W 4 0001 0000 wr_fill_1
W 4 0002 0000 wr_fill_2
W 4 0003 0000 wr_fill_3
W 4 0004 0000 wr_fill_4
W 4 0005 0000 wr_fill_5
W 4 0006 0000 wr_fill_6
W 4 0007 0000 wr_fill_7
W 4 0008 0000 wr_fill_8
W 4 0009 0000 wr_fill_9
R 0 7100 ffff wr_overflow
R 0 5100 ffff wr_ovf_cleared

//--- sim.f
+incdir+.
i2c_pkg.sv
i2c_fifo.sv
i2c_wb_regs.sv
i2c_byte_engine.sv
i2c_master_wbs_top.sv
tb_i2c_slave_model.sv
tb_i2c_master_wbs.sv

//--- Bender.yml
package:
  name: i2c_master_wbs

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - i2c_pkg.sv
      - i2c_fifo.sv
      - i2c_wb_regs.sv
      - i2c_byte_engine.sv
      - i2c_master_wbs_top.sv
  - target: test
    files:
      - tb_i2c_slave_model.sv
      - tb_i2c_master_wbs.sv
